//--- Makefile
SRCS := $(wildcard source/*.sv source/*.svh sim/*.sv)

all: run

obj_dir/Vrv_core_tb: rv_core.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module rv_core_tb -f rv_core.f

run: obj_dir/Vrv_core_tb
	./obj_dir/Vrv_core_tb | tee sim.log
	grep -q '^sim passed$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- rv_core.f
+incdir+source
source/rv_pkg.sv
source/hazard_if.sv
source/hazard_unit.sv
source/decode_ctrl.sv
source/reg_file.sv
source/rv_alu.sv
source/rv_core.sv
sim/rv_model_check.sv
sim/rv_core_tb.sv

//--- sim/rv_core_tb.sv
`include "rv_config.svh"

module rv_core_tb;
  logic                clk = 1'b0;
  logic                reset;
  logic                prog_we;
  logic [`IMEM_AW-1:0] prog_addr;
  logic [`XLEN-1:0]    prog_data;
  logic [`REG_AW-1:0]  dbg_addr;
  logic [`XLEN-1:0]    dbg_data;
  logic                is_halted;
  logic                check_done;
  int                  test_id;
  int                  errors;
  int                  checks;
  int                  timeouts;
  int                  seed;
  logic [31:0]         prog [$];

  always #4 clk = ~clk;

  rv_core rv_core_i (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data),
    .is_halted (is_halted)
  );

  rv_model_check model_check_i (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .is_halted (is_halted),
    .dbg_data  (dbg_data),
    .test_id   (test_id),
    .dbg_addr  (dbg_addr),
    .done      (check_done),
    .errors    (errors),
    .checks    (checks)
  );

  function automatic logic [31:0] r_instr(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_instr(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] store_instr(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};   // base x0
  endfunction

  function automatic logic [31:0] branch_instr(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'(1 + {$random(seed)} % 8);
  endfunction

  function automatic logic [4:0] pick_rd();
    return 5'({$random(seed)} % 9);   // x0 now and then
  endfunction

  function automatic logic [11:0] word_offset();
    return 12'({$random(seed)} % 16 * 4);
  endfunction

  // random register-register op, sub only via funct7
  function automatic logic [31:0] alu_rr(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    logic [2:0] f3_tab [6] = '{3'b000, 3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    int k;
    k = {$random(seed)} % 6;
    return r_instr(k == 1 ? 7'h20 : 7'h00, rs2, rs1, f3_tab[k], rd);
  endfunction

  function automatic logic [31:0] alu_ri(input logic [4:0] rd, input logic [4:0] rs1);
    logic [2:0] f3_tab [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    return i_instr(12'($random(seed)), rs1, f3_tab[{$random(seed)} % 5], rd, 7'h13);
  endfunction

  task automatic build_program();
    int limit;
    int skip;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [11:0] addr;
    prog.delete();
    for (int r = 1; r <= 8; r++) prog.push_back(i_instr(12'($random(seed)), 5'd0, 3'b000, 5'(r), 7'h13));
    limit = 32;   // branch targets never pass this index
    while (prog.size() < limit) begin
      case ({$random(seed)} % 10)
        0, 1: prog.push_back(alu_rr(pick_rd(), pick_reg(), pick_reg()));
        2, 3: prog.push_back(alu_ri(pick_rd(), pick_reg()));
        4: prog.push_back(i_instr(word_offset(), 5'd0, 3'b010, pick_rd(), 7'h03));
        5: prog.push_back(store_instr(word_offset(), pick_reg()));
        6: begin   // load-use
          ra = pick_reg();
          prog.push_back(i_instr(word_offset(), 5'd0, 3'b010, ra, 7'h03));
          prog.push_back(alu_rr(pick_rd(), ra, pick_reg()));
        end
        7: begin
          addr = word_offset();
          prog.push_back(store_instr(addr, pick_reg()));
          prog.push_back(i_instr(addr, 5'd0, 3'b010, pick_rd(), 7'h03));
        end
        8: begin
          skip = 1 + {$random(seed)} % 3;
          if (skip > limit - prog.size() - 1) skip = limit - prog.size() - 1;
          ra = pick_reg();
          rb = ({$random(seed)} % 4 == 0) ? ra : pick_reg();
          if (skip < 1) prog.push_back(alu_ri(pick_rd(), ra));
          else prog.push_back(branch_instr(13'((skip + 1) * 4), rb, ra, 3'({$random(seed)} % 2)));
        end
        default: begin   // chain through ex/mem and mem/wb forwarding
          ra = pick_reg();
          rb = pick_reg();
          prog.push_back(alu_ri(ra, rb));
          prog.push_back(alu_rr(rb, ra, ra));
          prog.push_back(alu_rr(pick_rd(), rb, ra));
        end
      endcase
    end
    prog.push_back(i_instr(12'(`HALT_CODE), 5'd0, 3'b000, 5'(`HALT_REG), 7'h13));
    prog.push_back(32'h0000_0073);                                  // ecall
    prog.push_back(i_instr(12'd1, 5'd1, 3'b000, 5'd1, 7'h13));      // must never commit
    prog.push_back(i_instr(12'hfff, 5'd0, 3'b000, 5'd2, 7'h13));
    prog.push_back(i_instr(12'd0, 5'd0, 3'b000, 5'(`HALT_REG), 7'h13));
  endtask

  // program goes in while the core sits in reset
  task automatic load_program();
    @(posedge clk);
    #1;
    reset = 1'b1;
    foreach (prog[i]) begin
      prog_we   = 1'b1;
      prog_addr = `IMEM_AW'(i);
      prog_data = prog[i];
      @(posedge clk);
      #1;
    end
    prog_we = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic wait_halt(output bit halted);
    int cycles;
    cycles = 0;
    while (!is_halted && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    halted = is_halted;
    if (!halted) begin
      $display("timeout: prog_%0d did not halt within 2000 cycles", test_id);
      timeouts++;
    end
  endtask

  task automatic wait_check();
    int cycles;
    cycles = 0;
    while (!check_done && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (!check_done) begin
      $display("timeout: register compare for prog_%0d never finished", test_id);
      timeouts++;
    end
  endtask

  initial begin
    bit halted;
    seed      = 31162;
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    test_id   = 0;
    timeouts  = 0;
    for (int t = 0; t < 20; t++) begin
      test_id = t;
      build_program();
      load_program();
      wait_halt(halted);
      if (halted) wait_check();
    end
    repeat (2) @(posedge clk);
    $display("tests 20, register checks %0d, mismatches %0d, timeouts %0d",
             checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sim/rv_model_check.sv
`include "rv_config.svh"

module rv_model_check (
  input  logic                clk,
  input  logic                reset,
  input  logic                prog_we,
  input  logic [`IMEM_AW-1:0] prog_addr,
  input  logic [`XLEN-1:0]    prog_data,
  input  logic                is_halted,
  input  logic [`XLEN-1:0]    dbg_data,
  input  int                  test_id,
  output logic [`REG_AW-1:0]  dbg_addr,
  output logic                done,
  output int                  errors,
  output int                  checks
);
  logic [31:0] prog_mem [2**`IMEM_AW];
  logic [31:0] exp_regs [32];
  logic [31:0] exp_mem [2**`DMEM_AW];

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return '0;
    endcase
  endfunction

  // runs the loaded program instruction by instruction, 1 when it halts
  function automatic bit run_model();
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] res;
    logic        wr;
    for (int r = 0; r < 32; r++) exp_regs[r] = '0;
    for (int m = 0; m < 2**`DMEM_AW; m++) exp_mem[m] = '0;
    pc = '0;
    for (int step = 0; step < 1000; step++) begin
      w       = prog_mem[pc[`IMEM_AW+1:2]];
      a       = exp_regs[w[19:15]];
      b       = exp_regs[w[24:20]];
      wr      = 1'b0;
      res     = '0;
      pc_next = pc + 4;
      case (w[6:0])
        7'h33: begin
          wr  = 1'b1;
          res = alu_ref(w[14:12], w[30], a, b);
        end
        7'h13: begin
          wr  = 1'b1;
          res = alu_ref(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
        end
        7'h03: begin
          wr  = 1'b1;
          ea  = a + {{20{w[31]}}, w[31:20]};
          res = exp_mem[ea[`DMEM_AW+1:2]];
        end
        7'h23: begin
          ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
          exp_mem[ea[`DMEM_AW+1:2]] = b;
        end
        7'h63: begin
          if ((a == b) != w[12]) pc_next = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        7'h73: begin
          if (exp_regs[`HALT_REG] == `HALT_CODE) return 1'b1;
        end
        default: ;
      endcase
      if (wr && w[11:7] != 5'd0) exp_regs[w[11:7]] = res;
      pc = pc_next;
    end
    return 1'b0;
  endfunction

  task automatic compare_regs();
    string name;
    name = $sformatf("prog_%0d", test_id);
    if (!run_model()) begin
      $display("%s: reference model never reached the halting ecall", name);
      errors++;
    end
    repeat (8) @(posedge clk);   // core must stay frozen meanwhile
    for (int r = 0; r < 32; r++) begin
      @(posedge clk);
      #1;
      dbg_addr = `REG_AW'(r);
      #2;
      checks++;
      if (dbg_data !== exp_regs[r]) begin
        $display("ERR %s x%0d expected %08h actual %08h", name, r, exp_regs[r], dbg_data);
        errors++;
      end
    end
    if (is_halted !== 1'b1) begin
      $display("ERR %s is_halted expected 1 actual %b", name, is_halted);
      errors++;
    end
    done = 1'b1;
  endtask

  initial begin
    dbg_addr = '0;
    done     = 1'b0;
    errors   = 0;
    checks   = 0;
    for (int i = 0; i < 2**`IMEM_AW; i++) prog_mem[i] = '0;
  end

  // mirror of the program image
  always @(posedge clk) begin
    if (prog_we) prog_mem[prog_addr] = prog_data;
  end

  always @(posedge clk) begin
    if (reset) begin
      done = 1'b0;
    end else if (is_halted && !done) begin
      compare_regs();
    end
  end

endmodule

//--- source/decode_ctrl.sv
`include "rv_config.svh"

module decode_ctrl
  import rv_pkg::*;
(
  input  instr_u           instr,
  output ctrl_t            ctrl,
  output logic [`XLEN-1:0] imm
);
  logic [`XLEN-1:0] i_imm;
  logic [`XLEN-1:0] s_imm;
  logic [`XLEN-1:0] b_imm;

  assign i_imm = {{(`XLEN-12){instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
  assign s_imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  // branch offset, bit 0 always zero
  assign b_imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_lo[0],
                  instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};

  always_comb begin
    ctrl        = '0;   // no-op unless decoded below
    ctrl.alu_op = alu_add;
    imm         = '0;
    case (instr.r.opcode)
      opc_op, opc_op_imm: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = (instr.r.opcode == opc_op_imm);
        imm            = i_imm;
        case (instr.r.funct3)
          3'b000: begin
            // sub only exists in the register form
            if (instr.r.opcode == opc_op && instr.r.funct7[5]) ctrl.alu_op = alu_sub;
            else ctrl.alu_op = alu_add;
          end
          3'b010: ctrl.alu_op = alu_slt;
          3'b100: ctrl.alu_op = alu_xor;
          3'b110: ctrl.alu_op = alu_or;
          3'b111: ctrl.alu_op = alu_and;
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      opc_load: begin
        if (instr.r.funct3 == 3'b010) begin   // lw only
          ctrl.alu_src    = 1'b1;
          ctrl.mem_read   = 1'b1;
          ctrl.mem_to_reg = 1'b1;
          ctrl.reg_write  = 1'b1;
          imm             = i_imm;
        end
      end
      opc_store: begin
        if (instr.s.funct3 == 3'b010) begin   // sw only
          ctrl.alu_src   = 1'b1;
          ctrl.mem_write = 1'b1;
          imm            = s_imm;
        end
      end
      opc_branch: begin
        ctrl.branch    = (instr.s.funct3 == 3'b000 || instr.s.funct3 == 3'b001);
        ctrl.branch_ne = (instr.s.funct3 == 3'b001);
        ctrl.alu_op    = alu_sub;
        imm            = b_imm;
      end
      opc_system: begin
        // ebreak differs only in the rs2 field
        ctrl.is_ecall = (instr.r.funct3 == 3'b000 && instr.r.rs2 == '0);
      end
      default: ;
    endcase
  end

endmodule

//--- source/hazard_if.sv
`include "rv_config.svh"

interface hazard_if;
  logic [`REG_AW-1:0] id_rs1;
  logic [`REG_AW-1:0] id_rs2;
  logic [`REG_AW-1:0] ex_rs1;
  logic [`REG_AW-1:0] ex_rs2;
  logic [`REG_AW-1:0] ex_rd;
  logic               ex_mem_read;   // load sitting in EX
  logic [`REG_AW-1:0] mem_rd;
  logic               mem_reg_write;
  logic [`REG_AW-1:0] wb_rd;
  logic               wb_reg_write;
  logic [1:0]         fwd_a;         // 0 reg, 1 wb data, 2 ex/mem alu
  logic [1:0]         fwd_b;
  logic               stall;

  modport core (
    output id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
    output mem_rd, mem_reg_write, wb_rd, wb_reg_write,
    input  fwd_a, fwd_b, stall
  );

  modport unit (
    input  id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_mem_read,
    input  mem_rd, mem_reg_write, wb_rd, wb_reg_write,
    output fwd_a, fwd_b, stall
  );
endinterface

//--- source/hazard_unit.sv
`include "rv_config.svh"

module hazard_unit (
  hazard_if.unit hz
);

  // pick the youngest producer of rs, x0 never forwarded
  function automatic logic [1:0] fwd_sel(
    input logic [`REG_AW-1:0] rs,
    input logic [`REG_AW-1:0] mem_rd,
    input logic               mem_we,
    input logic [`REG_AW-1:0] wb_rd,
    input logic               wb_we
  );
    if (rs == '0) begin
      return 2'd0;
    end
    if (mem_we && mem_rd == rs) begin
      return 2'd2;   // ex/mem wins
    end
    if (wb_we && wb_rd == rs) begin
      return 2'd1;
    end
    return 2'd0;
  endfunction

  assign hz.fwd_a = fwd_sel(hz.ex_rs1, hz.mem_rd, hz.mem_reg_write,
                            hz.wb_rd, hz.wb_reg_write);
  assign hz.fwd_b = fwd_sel(hz.ex_rs2, hz.mem_rd, hz.mem_reg_write,
                            hz.wb_rd, hz.wb_reg_write);

  // load result is not ready until WB, so hold the consumer one cycle
  always_comb begin
    hz.stall = 1'b0;
    if (hz.ex_mem_read && hz.ex_rd != '0) begin
      if (hz.ex_rd == hz.id_rs1 || hz.ex_rd == hz.id_rs2) begin
        hz.stall = 1'b1;
      end
    end
  end

endmodule

//--- source/reg_file.sv
`include "rv_config.svh"

module reg_file (
  input  logic               clk,
  input  logic               reset,
  input  logic [`REG_AW-1:0] rs1,
  input  logic [`REG_AW-1:0] rs2,
  input  logic [`REG_AW-1:0] rd,
  input  logic [`XLEN-1:0]   rd_data,
  input  logic               write_en,
  output logic [`XLEN-1:0]   rs1_data,
  output logic [`XLEN-1:0]   rs2_data,
  input  logic [`REG_AW-1:0] dbg_addr,
  output logic [`XLEN-1:0]   dbg_data
);
  logic [`XLEN-1:0] regs [1:2**`REG_AW-1];   // x0 has no storage

  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
    if (addr == '0) return '0;
    if (write_en && rd == addr) return rd_data;   // same-cycle bypass
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
    dbg_data = read_port(dbg_addr);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 2**`REG_AW; i++) regs[i] <= '0;
    end else if (write_en && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- source/rv_alu.sv
`include "rv_config.svh"

module rv_alu
  import rv_pkg::*;
(
  input  alu_op_t          alu_op,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] result,
  output logic             equal
);
  logic lt;

  assign lt = $signed(a) < $signed(b);   // slt is signed

  always_comb begin
    case (alu_op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = {{(`XLEN-1){1'b0}}, lt};
      default: result = '0;
    endcase
  end

  // beq/bne compare, polarity chosen by the core
  assign equal = (a == b);

endmodule

//--- source/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath and address width
`define XLEN 32

// register file address width, 32 registers
`define REG_AW 5

// instruction memory word address, 256 words
`define IMEM_AW 8

// data memory word address, 64 words
`define DMEM_AW 6

// ecall halts the core when x17 holds this value
`define HALT_CODE 10
`define HALT_REG 17

`endif

//--- source/rv_core.sv
`include "rv_config.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                prog_we,
  input  logic [`IMEM_AW-1:0] prog_addr,
  input  logic [`XLEN-1:0]    prog_data,
  input  logic [`REG_AW-1:0]  dbg_addr,
  output logic [`XLEN-1:0]    dbg_data,
  output logic                is_halted
);
  localparam logic [`XLEN-1:0] pc_step = 4;

  logic [`XLEN-1:0] imem [2**`IMEM_AW];
  logic [`XLEN-1:0] dmem [2**`DMEM_AW];

  logic [`XLEN-1:0]    pc;
  logic [`XLEN-1:0]    if_instr;
  logic                if_id_bubble;
  logic [`XLEN-1:0]    if_id_pc;
  instr_u              if_id_instr;
  ctrl_t               id_ctrl;
  logic [`XLEN-1:0]    id_imm;
  logic [`REG_AW-1:0]  id_rs1;
  logic [`XLEN-1:0]    id_rs1_data;
  logic [`XLEN-1:0]    id_rs2_data;
  logic                id_ex_bubble;
  ctrl_t               id_ex_ctrl;
  logic [`XLEN-1:0]    id_ex_pc;
  logic [`XLEN-1:0]    id_ex_imm;
  logic [`XLEN-1:0]    id_ex_rs1_data;
  logic [`XLEN-1:0]    id_ex_rs2_data;
  logic [`REG_AW-1:0]  id_ex_rs1;
  logic [`REG_AW-1:0]  id_ex_rs2;
  logic [`REG_AW-1:0]  id_ex_rd;
  logic [`XLEN-1:0]    op_a;
  logic [`XLEN-1:0]    op_b;
  logic [`XLEN-1:0]    alu_b;
  logic [`XLEN-1:0]    alu_result;
  logic [`XLEN-1:0]    br_target;
  logic                alu_equal;
  logic                ex_taken;
  logic                ex_halt;
  logic                ex_mem_bubble;
  logic                ex_mem_halt;
  ctrl_t               ex_mem_ctrl;
  logic [`XLEN-1:0]    ex_mem_alu;
  logic [`XLEN-1:0]    ex_mem_store;
  logic [`REG_AW-1:0]  ex_mem_rd;
  logic [`DMEM_AW-1:0] dmem_addr;
  logic [`XLEN-1:0]    mem_rdata;
  logic                mem_wb_bubble;
  logic                mem_wb_reg_write;
  logic                mem_wb_mem_to_reg;
  logic [`XLEN-1:0]    mem_wb_alu;
  logic [`XLEN-1:0]    mem_wb_load;
  logic [`REG_AW-1:0]  mem_wb_rd;
  logic [`XLEN-1:0]    wb_data;
  logic                wb_we;
  logic                halt_flush;
  logic                flush;

  hazard_if hz ();

  function automatic logic [`XLEN-1:0] fwd_mux(
    input logic [1:0]       sel,
    input logic [`XLEN-1:0] reg_val,
    input logic [`XLEN-1:0] wb_val,
    input logic [`XLEN-1:0] mem_val
  );
    case (sel)
      2'd1:    return wb_val;
      2'd2:    return mem_val;
      default: return reg_val;
    endcase
  endfunction

  // program load port, used while reset is held
  always_ff @(posedge clk) begin
    if (prog_we) imem[prog_addr] <= prog_data;
  end

  assign if_instr = imem[pc[`IMEM_AW+1:2]];

  // fetch always predicts pc+4
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (halt_flush) begin
      pc <= pc;              // fetch stopped for good
    end else if (ex_taken) begin
      pc <= br_target;
    end else if (!hz.stall) begin
      pc <= pc + pc_step;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      if_id_bubble <= 1'b1;
    end else if (!hz.stall) begin
      if_id_bubble <= 1'b0;
      if_id_pc     <= pc;
      if_id_instr  <= if_instr;
    end
  end

  decode_ctrl decode_i (
    .instr (if_id_instr),
    .ctrl  (id_ctrl),
    .imm   (id_imm)
  );

  // ecall reads x17 through the rs1 port
  assign id_rs1 = id_ctrl.is_ecall ? `REG_AW'(`HALT_REG) : if_id_instr.r.rs1;

  reg_file reg_file_i (
    .clk      (clk),
    .reset    (reset),
    .rs1      (id_rs1),
    .rs2      (if_id_instr.r.rs2),
    .rd       (mem_wb_rd),
    .rd_data  (wb_data),
    .write_en (wb_we),
    .rs1_data (id_rs1_data),
    .rs2_data (id_rs2_data),
    .dbg_addr (dbg_addr),
    .dbg_data (dbg_data)
  );

  assign hz.id_rs1        = id_rs1;
  assign hz.id_rs2        = if_id_instr.r.rs2;
  assign hz.ex_rs1        = id_ex_rs1;
  assign hz.ex_rs2        = id_ex_rs2;
  assign hz.ex_rd         = id_ex_rd;
  assign hz.ex_mem_read   = id_ex_ctrl.mem_read;
  assign hz.mem_rd        = ex_mem_rd;
  assign hz.mem_reg_write = ex_mem_ctrl.reg_write && !ex_mem_bubble;
  assign hz.wb_rd         = mem_wb_rd;
  assign hz.wb_reg_write  = wb_we;

  hazard_unit hazard_i (
    .hz (hz)
  );

  always_ff @(posedge clk) begin
    if (reset || flush || hz.stall) begin
      id_ex_bubble <= 1'b1;
      id_ex_ctrl   <= '0;
    end else begin
      id_ex_bubble   <= if_id_bubble;
      id_ex_ctrl     <= if_id_bubble ? '0 : id_ctrl;
      id_ex_pc       <= if_id_pc;
      id_ex_imm      <= id_imm;
      id_ex_rs1_data <= id_rs1_data;
      id_ex_rs2_data <= id_rs2_data;
      id_ex_rs1      <= id_rs1;
      id_ex_rs2      <= if_id_instr.r.rs2;
      id_ex_rd       <= if_id_instr.r.rd;
    end
  end

  assign op_a  = fwd_mux(hz.fwd_a, id_ex_rs1_data, wb_data, ex_mem_alu);
  assign op_b  = fwd_mux(hz.fwd_b, id_ex_rs2_data, wb_data, ex_mem_alu);
  assign alu_b = id_ex_ctrl.alu_src ? id_ex_imm : op_b;

  rv_alu alu_i (
    .alu_op (id_ex_ctrl.alu_op),
    .a      (op_a),
    .b      (alu_b),
    .result (alu_result),
    .equal  (alu_equal)
  );

  assign br_target = id_ex_pc + id_ex_imm;
  assign ex_taken  = !id_ex_bubble && id_ex_ctrl.branch && (alu_equal != id_ex_ctrl.branch_ne);
  assign ex_halt   = !id_ex_bubble && id_ex_ctrl.is_ecall && op_a == `XLEN'(`HALT_CODE);

  // once a halting ecall leaves decode, nothing younger gets through
  assign halt_flush = ex_halt || ex_mem_halt || is_halted;
  assign flush      = ex_taken || halt_flush;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_bubble <= 1'b1;
      ex_mem_ctrl   <= '0;
      ex_mem_halt   <= 1'b0;
    end else begin
      ex_mem_bubble <= id_ex_bubble;
      ex_mem_ctrl   <= id_ex_ctrl;
      ex_mem_halt   <= ex_halt;
      ex_mem_alu    <= alu_result;
      ex_mem_store  <= op_b;   // forwarded rs2 for sw
      ex_mem_rd     <= id_ex_rd;
    end
  end

  assign dmem_addr = ex_mem_alu[`DMEM_AW+1:2];
  assign mem_rdata = ex_mem_ctrl.mem_read ? dmem[dmem_addr] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`DMEM_AW; i++) dmem[i] <= '0;
    end else if (ex_mem_ctrl.mem_write && !ex_mem_bubble) begin
      dmem[dmem_addr] <= ex_mem_store;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb_bubble     <= 1'b1;
      mem_wb_reg_write  <= 1'b0;
      mem_wb_mem_to_reg <= 1'b0;
    end else begin
      mem_wb_bubble     <= ex_mem_bubble;
      mem_wb_reg_write  <= ex_mem_ctrl.reg_write;
      mem_wb_mem_to_reg <= ex_mem_ctrl.mem_to_reg;
      mem_wb_alu        <= ex_mem_alu;
      mem_wb_load       <= mem_rdata;
      mem_wb_rd         <= ex_mem_rd;
    end
  end

  assign wb_data = mem_wb_mem_to_reg ? mem_wb_load : mem_wb_alu;
  assign wb_we   = mem_wb_reg_write && !mem_wb_bubble;

  // rises as the ecall enters WB, sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      is_halted <= 1'b0;
    end else if (ex_mem_halt) begin
      is_halted <= 1'b1;
    end
  end

endmodule

//--- source/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  // RV32I major opcodes supported by the core
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_system = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_t;

  // control bundle, built in decode
  typedef struct packed {
    logic    alu_src;    // b operand from immediate
    alu_op_t alu_op;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg; // writeback from load data
    logic    reg_write;
    logic    branch;
    logic    branch_ne;  // bne instead of beq
    logic    is_ecall;
  } ctrl_t;

  // register view, also used for I-type
  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    opcode_t            opcode;
  } r_view_t;

  // store view, also used for B-type
  typedef struct packed {
    logic [6:0]         imm_hi;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [4:0]         imm_lo;
    opcode_t            opcode;
  } s_view_t;

  typedef union packed {
    r_view_t r;
    s_view_t s;
  } instr_u;

endpackage
